// ==== logic/rv_exec_pkg.sv ====
// RV64I types and encodings only; the 64-bit width and 32 registers are fixed by the ISA
`default_nettype none

package rv_exec_pkg;

	typedef logic [63:0] xlen_t;    // register and operand value
	typedef logic [31:0] instr_t;   // raw instruction word
	typedef logic [4:0]  reg_idx_t; // x0..x31
	typedef logic [10:0] alu_ctrl_t; // one-hot ALU operation select

	// one-hot bit positions in alu_ctrl_t
	localparam int unsigned ALU_ADD  = 0;
	localparam int unsigned ALU_SUB  = 1;
	localparam int unsigned ALU_SLT  = 2;
	localparam int unsigned ALU_SLTU = 3;
	localparam int unsigned ALU_AND  = 4;
	localparam int unsigned ALU_OR   = 5;
	localparam int unsigned ALU_XOR  = 6;
	localparam int unsigned ALU_SLL  = 7;
	localparam int unsigned ALU_SRL  = 8;
	localparam int unsigned ALU_SRA  = 9;
	localparam int unsigned ALU_LUI  = 10;

	// major opcodes, instr[6:0]
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;

endpackage

`default_nettype wire

// ==== logic/instr_decoder.sv ====
// covers OP, OP-IMM and LUI only; anything else comes out illegal with no write and zero ALU control
`timescale 1ns/100ps
`default_nettype none

module instr_decoder
	import rv_exec_pkg::*;
(
	input  instr_t    instr,
	output reg_idx_t  rs1,
	output reg_idx_t  rs2,
	output reg_idx_t  rd,
	output xlen_t     imm,
	output logic      use_imm,
	output logic      reg_write,
	output logic      illegal,
	output alu_ctrl_t alu_ctrl
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [5:0] funct6;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign funct6 = instr[31:26]; // RV64 shift-immediates use a 6-bit shamt

	assign rd = instr[11:7];

	always_comb begin
		rs1       = '0;
		rs2       = '0;
		imm       = '0;
		use_imm   = 1'b0;
		reg_write = 1'b1;
		illegal   = 1'b0;
		alu_ctrl  = '0;
		case (opcode)
			OPC_OP: begin
				rs1 = instr[19:15];
				rs2 = instr[24:20];
				if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000: alu_ctrl[ALU_ADD]  = 1'b1;
						3'b001: alu_ctrl[ALU_SLL]  = 1'b1;
						3'b010: alu_ctrl[ALU_SLT]  = 1'b1;
						3'b011: alu_ctrl[ALU_SLTU] = 1'b1;
						3'b100: alu_ctrl[ALU_XOR]  = 1'b1;
						3'b101: alu_ctrl[ALU_SRL]  = 1'b1;
						3'b110: alu_ctrl[ALU_OR]   = 1'b1;
						default: alu_ctrl[ALU_AND] = 1'b1;
					endcase
				end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					alu_ctrl[ALU_SUB] = 1'b1;
				end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
					alu_ctrl[ALU_SRA] = 1'b1;
				end else begin
					illegal = 1'b1;
				end
			end
			OPC_OP_IMM: begin
				rs1     = instr[19:15];
				use_imm = 1'b1;
				imm     = {{52{instr[31]}}, instr[31:20]}; // sign-extended I immediate
				case (funct3)
					3'b000: alu_ctrl[ALU_ADD]  = 1'b1;
					3'b010: alu_ctrl[ALU_SLT]  = 1'b1;
					3'b011: alu_ctrl[ALU_SLTU] = 1'b1;
					3'b100: alu_ctrl[ALU_XOR]  = 1'b1;
					3'b110: alu_ctrl[ALU_OR]   = 1'b1;
					3'b111: alu_ctrl[ALU_AND]  = 1'b1;
					3'b001: begin
						imm = {58'b0, instr[25:20]}; // shamt only
						if (funct6 == 6'b000000)
							alu_ctrl[ALU_SLL] = 1'b1;
						else
							illegal = 1'b1;
					end
					default: begin // 3'b101, SRLI or SRAI
						imm = {58'b0, instr[25:20]};
						if (funct6 == 6'b000000)
							alu_ctrl[ALU_SRL] = 1'b1;
						else if (funct6 == 6'b010000)
							alu_ctrl[ALU_SRA] = 1'b1;
						else
							illegal = 1'b1;
					end
				endcase
			end
			OPC_LUI: begin
				use_imm = 1'b1;
				imm     = {32'b0, instr}; // ALU picks bits 31:12
				alu_ctrl[ALU_LUI] = 1'b1;
			end
			default: illegal = 1'b1;
		endcase
		if (illegal) begin
			rs1       = '0;
			rs2       = '0;
			imm       = '0;
			use_imm   = 1'b0;
			reg_write = 1'b0;
			alu_ctrl  = '0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
// 32 x 64 register file with combinational reads that see the old value during a write; x0 reads zero
`timescale 1ns/100ps
`default_nettype none

module reg_file
	import rv_exec_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  logic     wr_en,
	input  reg_idx_t wr_idx,
	input  xlen_t    wr_data,
	output xlen_t    rd_data1,
	output xlen_t    rd_data2
);

	xlen_t regs [1:31]; // no storage for x0

	// all registers clear to zero
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign rd_data1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rd_data2 = (rs2 == '0) ? '0 : regs[rs2];

	// top is expected to drop x0 writes before they get here
	a_no_x0_write: assert property (
		@(posedge clk) disable iff (!arst_n)
		wr_en |-> (wr_idx != '0)
	) else $error("register file write to x0");

endmodule

`default_nettype wire

// ==== logic/operand_stage.sv ====
// issue register; forwarding is applied on the registered operands, only from the one result register
`timescale 1ns/100ps
`default_nettype none

module operand_stage
	import rv_exec_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      instr_valid,
	input  reg_idx_t  rs1,
	input  reg_idx_t  rs2,
	input  reg_idx_t  rd,
	input  xlen_t     rf_data1,
	input  xlen_t     rf_data2,
	input  xlen_t     imm,
	input  logic      use_imm,
	input  logic      reg_write,
	input  logic      illegal,
	input  alu_ctrl_t alu_ctrl,
	input  logic      fwd_en,
	input  reg_idx_t  fwd_idx,
	input  xlen_t     fwd_data,
	output logic      ex_valid,
	output xlen_t     src1,
	output xlen_t     src2,
	output alu_ctrl_t ex_alu_ctrl,
	output reg_idx_t  ex_rd,
	output logic      ex_reg_write,
	output logic      ex_illegal
);

	reg_idx_t ex_rs1;
	reg_idx_t ex_rs2;
	xlen_t    ex_rf1;
	xlen_t    ex_rf2;
	xlen_t    ex_imm;
	logic     ex_use_imm;
	logic     hit1;
	logic     hit2;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid     <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_illegal   <= 1'b0;
			ex_alu_ctrl  <= '0;
		end else begin
			ex_valid <= instr_valid;
			if (instr_valid) begin
				ex_reg_write <= reg_write;
				ex_illegal   <= illegal;
				ex_alu_ctrl  <= alu_ctrl;
			end
		end
	end

	// operand payload
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			ex_rs1     <= rs1;
			ex_rs2     <= rs2;
			ex_rf1     <= rf_data1;
			ex_rf2     <= rf_data2;
			ex_imm     <= imm;
			ex_use_imm <= use_imm;
			ex_rd      <= rd;
		end
	end

	// rf data was read before the producer's write landed
	assign hit1 = fwd_en && (fwd_idx == ex_rs1);
	assign hit2 = fwd_en && (fwd_idx == ex_rs2);

	assign src1 = hit1 ? fwd_data : ex_rf1;
	assign src2 = ex_use_imm ? ex_imm
		: hit2 ? fwd_data : ex_rf2;

	a_ctrl_onehot: assert property (
		@(posedge clk) disable iff (!arst_n)
		ex_valid |-> $onehot0(ex_alu_ctrl)
	) else $error("ALU control not one-hot in execute");

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
// 64-bit one-hot ALU where zero control gives a zero result; shifts use src2[5:0] and LUI reads src2[31:12]
`timescale 1ns/100ps
`default_nettype none

module alu
	import rv_exec_pkg::*;
(
	input  alu_ctrl_t alu_ctrl,
	input  xlen_t     alu_src1,
	input  xlen_t     alu_src2,
	output xlen_t     alu_result
);

	logic  op_sub_like; // sub and both compares go through the inverted path
	xlen_t adder_b;
	logic  adder_cin;
	xlen_t adder_result;
	logic  adder_cout;

	xlen_t slt_result;
	xlen_t sltu_result;
	xlen_t sll_result;
	xlen_t srl_result;
	xlen_t sra_result;
	xlen_t lui_result;

	assign op_sub_like = alu_ctrl[ALU_SUB] | alu_ctrl[ALU_SLT] | alu_ctrl[ALU_SLTU];

	assign adder_b   = op_sub_like ? ~alu_src2 : alu_src2;
	assign adder_cin = op_sub_like;
	assign {adder_cout, adder_result} = {1'b0, alu_src1} + {1'b0, adder_b} + {64'b0, adder_cin};

	// src1 negative and src2 not, or same sign and negative difference
	assign slt_result = {63'b0, (alu_src1[63] & ~alu_src2[63])
		| (~(alu_src1[63] ^ alu_src2[63]) & adder_result[63])};
	assign sltu_result = {63'b0, ~adder_cout}; // borrow out

	assign sll_result = alu_src1 << alu_src2[5:0];
	assign srl_result = alu_src1 >> alu_src2[5:0];
	assign sra_result = $signed(alu_src1) >>> alu_src2[5:0];

	assign lui_result = {{32{alu_src2[31]}}, alu_src2[31:12], 12'b0};

	assign alu_result = ({64{alu_ctrl[ALU_ADD] | alu_ctrl[ALU_SUB]}} & adder_result)
		| ({64{alu_ctrl[ALU_SLT]}}  & slt_result)
		| ({64{alu_ctrl[ALU_SLTU]}} & sltu_result)
		| ({64{alu_ctrl[ALU_AND]}}  & (alu_src1 & alu_src2))
		| ({64{alu_ctrl[ALU_OR]}}   & (alu_src1 | alu_src2))
		| ({64{alu_ctrl[ALU_XOR]}}  & (alu_src1 ^ alu_src2))
		| ({64{alu_ctrl[ALU_SLL]}}  & sll_result)
		| ({64{alu_ctrl[ALU_SRL]}}  & srl_result)
		| ({64{alu_ctrl[ALU_SRA]}}  & sra_result)
		| ({64{alu_ctrl[ALU_LUI]}}  & lui_result);

	always_comb begin
		assert ($onehot0(alu_ctrl))
		else $error("ALU control has more than one bit set");
	end

endmodule

`default_nettype wire

// ==== logic/int_exec_unit.sv ====
// fixed two-cycle latency, no back-pressure; illegal encodings and x0 targets retire without a write
`timescale 1ns/100ps
`default_nettype none

module int_exec_unit
	import rv_exec_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     instr_valid,
	input  instr_t   instr,
	output logic     retire_valid,
	output reg_idx_t retire_rd,
	output xlen_t    retire_value,
	output logic     retire_illegal
);

	reg_idx_t  rs1;
	reg_idx_t  rs2;
	reg_idx_t  rd;
	xlen_t     imm;
	logic      use_imm;
	logic      reg_write;
	logic      illegal;
	alu_ctrl_t alu_ctrl;

	xlen_t     rf_data1;
	xlen_t     rf_data2;

	logic      ex_valid;
	xlen_t     src1;
	xlen_t     src2;
	alu_ctrl_t ex_alu_ctrl;
	reg_idx_t  ex_rd;
	logic      ex_reg_write;
	logic      ex_illegal;
	xlen_t     alu_result;

	logic      wb_en;  // write-back this edge
	logic      res_wr; // result register holds a live write

	instr_decoder instr_decoder_i (
		.instr     (instr),
		.rs1       (rs1),
		.rs2       (rs2),
		.rd        (rd),
		.imm       (imm),
		.use_imm   (use_imm),
		.reg_write (reg_write),
		.illegal   (illegal),
		.alu_ctrl  (alu_ctrl)
	);

	reg_file reg_file_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs1      (rs1),
		.rs2      (rs2),
		.wr_en    (wb_en),
		.wr_idx   (ex_rd),
		.wr_data  (alu_result),
		.rd_data1 (rf_data1),
		.rd_data2 (rf_data2)
	);

	operand_stage operand_stage_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.instr_valid  (instr_valid),
		.rs1          (rs1),
		.rs2          (rs2),
		.rd           (rd),
		.rf_data1     (rf_data1),
		.rf_data2     (rf_data2),
		.imm          (imm),
		.use_imm      (use_imm),
		.reg_write    (reg_write),
		.illegal      (illegal),
		.alu_ctrl     (alu_ctrl),
		.fwd_en       (retire_valid & res_wr),
		.fwd_idx      (retire_rd),
		.fwd_data     (retire_value),
		.ex_valid     (ex_valid),
		.src1         (src1),
		.src2         (src2),
		.ex_alu_ctrl  (ex_alu_ctrl),
		.ex_rd        (ex_rd),
		.ex_reg_write (ex_reg_write),
		.ex_illegal   (ex_illegal)
	);

	alu alu_i (
		.alu_ctrl   (ex_alu_ctrl),
		.alu_src1   (src1),
		.alu_src2   (src2),
		.alu_result (alu_result)
	);

	assign wb_en = ex_valid & ex_reg_write & ~ex_illegal & (ex_rd != '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			retire_valid   <= 1'b0;
			retire_illegal <= 1'b0;
			res_wr         <= 1'b0;
		end else begin
			retire_valid <= ex_valid;
			if (ex_valid) begin
				retire_illegal <= ex_illegal;
				res_wr         <= wb_en; // also the forwarding qualifier
			end
		end
	end

	// the value is reported even for x0
	always_ff @(posedge clk) begin
		if (ex_valid) begin
			retire_rd    <= ex_rd;
			retire_value <= alu_result;
		end
	end

	// strobe to retire through issue and result registers
	a_retire_latency: assert property (
		@(posedge clk) disable iff (!arst_n)
		retire_valid == $past(instr_valid, 2)
	) else $error("retire_valid not two cycles after instr_valid");

endmodule

`default_nettype wire

// ==== include/exec_ref_model.svh ====
// testbench model for OP, OP-IMM and LUI only; rs1_val and rs2_val are the architectural source values
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

function automatic void exec_ref(
	input  logic [31:0] instr,
	input  logic [63:0] rs1_val,
	input  logic [63:0] rs2_val,
	output logic [63:0] value,
	output logic        illegal
);
	logic [2:0]  f3;
	logic [6:0]  f7;
	logic [63:0] b;
	logic [5:0]  sh;
	f3      = instr[14:12];
	f7      = instr[31:25];
	value   = '0;
	illegal = 1'b0;
	if (instr[6:0] == rv_exec_pkg::OPC_LUI) begin
		value = {{32{instr[31]}}, instr[31:12], 12'b0};
	end else if (instr[6:0] == rv_exec_pkg::OPC_OP || instr[6:0] == rv_exec_pkg::OPC_OP_IMM) begin
		b  = (instr[6:0] == rv_exec_pkg::OPC_OP) ? rs2_val : {{52{instr[31]}}, instr[31:20]};
		sh = b[5:0];
		if (instr[6:0] == rv_exec_pkg::OPC_OP)
			illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
		else if (f3 == 3'b001)
			illegal = (instr[31:26] != 6'b000000);
		else if (f3 == 3'b101)
			illegal = (instr[31:26] != 6'b000000 && instr[31:26] != 6'b010000);
		case (f3)
			3'b000: value = (instr[6:0] == rv_exec_pkg::OPC_OP && f7[5]) ? rs1_val - b : rs1_val + b;
			3'b001: value = rs1_val << sh;
			3'b010: value = {63'b0, $signed(rs1_val) < $signed(b)};
			3'b011: value = {63'b0, rs1_val < b};
			3'b100: value = rs1_val ^ b;
			3'b101: value = instr[30] ? 64'($signed(rs1_val) >>> sh) : rs1_val >> sh;
			3'b110: value = rs1_val | b;
			default: value = rs1_val & b;
		endcase
	end else begin
		illegal = 1'b1;
	end
	if (illegal)
		value = '0;
endfunction

`endif

// ==== tests/tb_int_exec_unit.sv ====
// drives one strobe per cycle at most; the shadow model covers OP, OP-IMM and LUI only
`timescale 1ns/100ps
`default_nettype none

module tb_int_exec_unit
	import rv_exec_pkg::*;
();

	`include "exec_ref_model.svh"

	localparam int RETIRE_GAP = 3; // drive edge to the edge that first sees retire_valid
	localparam logic [17:0] I_F3 = {3'b111, 3'b110, 3'b100, 3'b011, 3'b010, 3'b000};
	localparam logic [23:0] SHAMTS = {6'd63, 6'd32, 6'd1, 6'd0};

	logic     clk = 1'b0;
	logic     arst_n;
	logic     instr_valid;
	instr_t   instr;
	logic     retire_valid;
	reg_idx_t retire_rd;
	xlen_t    retire_value;
	logic     retire_illegal;

	xlen_t    shadow [0:31]; // architectural registers as the model sees them
	xlen_t    exp_value [$];
	reg_idx_t exp_rd [$];
	logic     exp_illegal [$];
	int       exp_cyc [$];

	int seed;
	int cyc = 0;
	int issued;
	int errors;
	int err_mark;
	int n_pass;
	int n_fail;

	int_exec_unit int_exec_unit_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.instr_valid    (instr_valid),
		.instr          (instr),
		.retire_valid   (retire_valid),
		.retire_rd      (retire_rd),
		.retire_value   (retire_value),
		.retire_illegal (retire_illegal)
	);

	always #10 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	function automatic logic [31:0] op_instr(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] imm_instr(input logic [11:0] imm, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1);
		return {imm, rs1, f3, rd, OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] lui_instr(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, OPC_LUI};
	endfunction

	// {funct7, funct3} of the ten R-type operations
	function automatic logic [9:0] r_sel(input int k);
		case (k)
			0: return {7'h00, 3'b000}; // add
			1: return {7'h20, 3'b000}; // sub
			2: return {7'h00, 3'b010};
			3: return {7'h00, 3'b011};
			4: return {7'h00, 3'b111};
			5: return {7'h00, 3'b110};
			6: return {7'h00, 3'b100};
			7: return {7'h00, 3'b001};
			8: return {7'h00, 3'b101};
			default: return {7'h20, 3'b101}; // sra
		endcase
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic send_instr(input logic [31:0] w);
		xlen_t    v;
		logic     ill;
		reg_idx_t d;
		d = w[11:7];
		exec_ref(w, shadow[w[19:15]], shadow[w[24:20]], v, ill);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= w;
		exp_value.push_back(v);
		exp_rd.push_back(d);
		exp_illegal.push_back(ill);
		exp_cyc.push_back(cyc);
		issued++;
		if (!ill && d != 5'd0)
			shadow[d] = v;
	endtask

	// 9 + 5 x 11 bits with each step depending on the one before
	task automatic load_reg(input logic [4:0] r, input xlen_t v);
		send_instr(imm_instr({3'b000, v[63:55]}, 3'b000, r, 5'd0));
		for (int i = 4; i >= 0; i--) begin
			send_instr(imm_instr(12'd11, 3'b001, r, r));
			send_instr(imm_instr({1'b0, v[i * 11 +: 11]}, 3'b110, r, r));
		end
	endtask

	task automatic run_r_ops(input xlen_t a, input xlen_t b);
		logic [9:0] sel;
		load_reg(5'd1, a);
		load_reg(5'd2, b);
		for (int k = 0; k < 10; k++) begin
			sel = r_sel(k);
			send_instr(op_instr(sel[9:3], sel[2:0], 5'(5 + k), 5'd1, 5'd2));
		end
	endtask

	task automatic run_i_ops(input xlen_t a);
		logic [5:0] sh;
		load_reg(5'd1, a);
		send_instr(imm_instr(12'hfff, 3'b000, 5'd3, 5'd1)); // addi -1
		send_instr(imm_instr(12'h800, 3'b010, 5'd4, 5'd1)); // most negative imm
		for (int k = 0; k < 6; k++)
			send_instr(imm_instr(12'($random(seed)), I_F3[k * 3 +: 3], 5'(5 + k), 5'd1));
		for (int s = 0; s < 4; s++) begin
			sh = SHAMTS[s * 6 +: 6];
			send_instr(imm_instr({6'b000000, sh}, 3'b001, 5'd12, 5'd1));
			send_instr(imm_instr({6'b000000, sh}, 3'b101, 5'd13, 5'd1));
			send_instr(imm_instr({6'b010000, sh}, 3'b101, 5'd14, 5'd1));
		end
	endtask

	// stop driving, wait for every outstanding retire, then report
	task automatic close_test(input string name);
		int waited;
		@(posedge clk);
		instr_valid <= 1'b0;
		waited = 0;
		while (exp_rd.size() != 0 && waited < 2 * RETIRE_GAP) begin
			@(posedge clk);
			waited++;
		end
		if (exp_rd.size() != 0) begin
			$display("test %s: %0d expected retires never arrived", name, exp_rd.size());
			errors++;
			exp_value.delete();
			exp_rd.delete();
			exp_illegal.delete();
			exp_cyc.delete();
		end
		if (errors == err_mark) begin
			n_pass++;
			$display("test %s: pass", name);
		end else begin
			n_fail++;
			$display("test %s: FAIL with %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	always @(posedge clk) begin
		if (arst_n && retire_valid) begin
			if (exp_rd.size() == 0) begin
				$display("retire at %0t with no instruction outstanding", $time);
				errors++;
			end else begin
				check_val("retire_rd", 64'(retire_rd), 64'(exp_rd.pop_front()));
				check_val("retire_value", retire_value, exp_value.pop_front());
				check_val("retire_illegal", 64'(retire_illegal), 64'(exp_illegal.pop_front()));
				check_val("retire latency", 64'(cyc - exp_cyc.pop_front()), 64'(RETIRE_GAP));
			end
		end
	end

	// limit grows with the number of issued instructions
	always @(posedge clk) begin
		if (cyc > 20 * issued + 200) begin
			$display("timeout after %0d cycles with %0d instructions issued", cyc, issued);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		xlen_t      a;
		xlen_t      b;
		int         prev;
		int         d;
		logic [9:0] sel;
		seed        = 16;
		issued      = 0;
		errors      = 0;
		err_mark    = 0;
		n_pass      = 0;
		n_fail      = 0;
		arst_n      = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		for (int r = 0; r < 32; r++)
			shadow[r] = '0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;

		repeat (5) begin
			@(posedge clk);
			check_val("retire_valid", 64'(retire_valid), 64'd0); // nothing issued yet
		end
		send_instr(lui_instr(20'h12345, 5'd1));
		send_instr(imm_instr(12'h678, 3'b000, 5'd1, 5'd1));
		send_instr(lui_instr(20'h80000, 5'd2)); // upper half all ones
		send_instr(imm_instr(12'hfff, 3'b000, 5'd2, 5'd2));
		send_instr(imm_instr(12'h7ff, 3'b000, 5'd3, 5'd0));
		close_test("reset and load");

		for (int k = 0; k < 3; k++)
			run_r_ops({$random(seed), $random(seed)}, {$random(seed), $random(seed)});
		a = {$random(seed), $random(seed)} | 64'h8000_0000_0000_0000;
		b = {$random(seed), $random(seed)} & 64'h7fff_ffff_ffff_ffff;
		run_r_ops(a, b); // signs differ both ways
		run_r_ops(b, a);
		run_r_ops(a, 64'd0);
		run_r_ops(a, 64'd31);
		run_r_ops(a, 64'd32);
		run_r_ops(a, 64'hffff_ffff_ffff_ff3f); // amount 63 with the upper bits ignored
		close_test("R-type");

		run_i_ops({$random(seed), $random(seed)} | 64'h8000_0000_0000_0000);
		run_i_ops({$random(seed), $random(seed)} & 64'h7fff_ffff_ffff_ffff);
		run_i_ops({$random(seed), $random(seed)});
		close_test("I-type");

		for (int c = 0; c < 4; c++) begin
			load_reg(5'd7, {$random(seed), $random(seed)});
			prev = 7;
			for (int j = 0; j < 8; j++) begin
				d   = 8 + int'($unsigned($random(seed)) % 8);
				sel = r_sel(int'($unsigned($random(seed)) % 10));
				send_instr(op_instr(sel[9:3], sel[2:0], 5'(d), 5'(prev), 5'(prev)));
				prev = d;
			end
		end
		close_test("dependent chains");

		load_reg(5'd1, 64'h0123_4567_89ab_cdef);
		send_instr(imm_instr(12'h005, 3'b000, 5'd0, 5'd1));
		send_instr(op_instr(7'h00, 3'b000, 5'd3, 5'd0, 5'd1)); // x0 right after its write
		send_instr(lui_instr(20'hfffff, 5'd0));
		send_instr(op_instr(7'h00, 3'b110, 5'd4, 5'd0, 5'd0));
		close_test("x0 writes");

		load_reg(5'd5, 64'hfeed_0000_cafe_0001);
		send_instr({12'h010, 5'd1, 3'b011, 5'd5, 7'b0000011}); // ld
		send_instr(op_instr(7'h01, 3'b000, 5'd5, 5'd1, 5'd2)); // mul
		send_instr(op_instr(7'h20, 3'b001, 5'd5, 5'd1, 5'd2));
		send_instr(imm_instr({6'b010000, 6'd3}, 3'b001, 5'd5, 5'd1));
		send_instr(imm_instr({6'b000001, 6'd3}, 3'b101, 5'd5, 5'd1));
		send_instr({20'h12345, 5'd5, 7'b0010111}); // auipc
		send_instr(32'hffff_ffff);
		send_instr(op_instr(7'h00, 3'b000, 5'd8, 5'd5, 5'd0)); // x5 must be unchanged
		send_instr(op_instr(7'h00, 3'b000, 5'd9, 5'd31, 5'd0));
		close_test("illegal encodings");

		$display("tests passed: %0d, failed: %0d, check errors: %0d", n_pass, n_fail, errors);
		if (errors == 0 && n_fail == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
logic/rv_exec_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/operand_stage.sv
logic/alu.sv
logic/int_exec_unit.sv
tests/tb_int_exec_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_int_exec_unit -Mdir obj_dir; then
	echo "build failed"
	exit 1
fi

if ! out=$(./obj_dir/Vtb_int_exec_unit); then
	printf '%s\n' "$out"
	echo "simulation exited with an error"
	exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF '*** PASSED ***'; then
	exit 0
fi
echo "pass message not found"
exit 1
